// File: adder_pkg.sv
// Brent-Kung adder shared definitions
package adder_pkg;

    // Operand width when the top level is not overridden
    localparam int DEFAULT_WIDTH = 16;

    // Round states of the stage sequencer
    typedef enum logic [1:0] {
        IDLE      = 2'b00,  // One cycle gap between rounds
        RAMP_UP   = 2'b01,  // Stages evaluate in order
        RAMP_DOWN = 2'b10,  // Stages clear in reverse order
        DONE      = 2'b11   // Result valid for one cycle
    } seq_state_t;

endpackage

// File: phase_sequencer.sv
`timescale 1ns/10ps
// Bennett round sequencer
// Evaluates stages in order, clears them in reverse, then flags done

module phase_sequencer #(
    parameter  int WIDTH      = adder_pkg::DEFAULT_WIDTH,
    localparam int LEVELS     = $clog2(WIDTH),
    localparam int NUM_STAGES = 2 * LEVELS + 1
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic [NUM_STAGES-1:0] eval,
    output logic [NUM_STAGES-1:0] clear,
    output logic                  calculation_done
);

    localparam int CNT_W = $clog2(NUM_STAGES);
    localparam logic [NUM_STAGES-1:0] ONE = 1;

    adder_pkg::seq_state_t state;
    logic [CNT_W-1:0]      count;   // Position within the current ramp

    // Prefix tree needs a power-of-two width with at least two levels
    if (WIDTH < 4 || (WIDTH & (WIDTH - 1)) != 0) begin : g_bad_width
        $error("Operand width must be a power of two of at least 4");
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= adder_pkg::IDLE;
            count <= '0;
        end else begin
            case (state)
                adder_pkg::IDLE: begin
                    state <= adder_pkg::RAMP_UP;
                    count <= '0;
                end
                adder_pkg::RAMP_UP: begin
                    if (count == CNT_W'(NUM_STAGES - 1)) begin
                        state <= adder_pkg::RAMP_DOWN;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                adder_pkg::RAMP_DOWN: begin
                    // Sum stage keeps its result, so one clear fewer
                    if (count == CNT_W'(NUM_STAGES - 2)) begin
                        state <= adder_pkg::DONE;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                adder_pkg::DONE: begin
                    state <= adder_pkg::IDLE;
                end
                default: begin
                    state <= adder_pkg::IDLE;
                    count <= '0;
                end
            endcase
        end
    end

    always_comb begin
        eval             = '0;
        clear            = '0;
        calculation_done = 1'b0;
        case (state)
            adder_pkg::RAMP_UP:   eval  = ONE << count;
            adder_pkg::RAMP_DOWN: clear = ONE << (CNT_W'(NUM_STAGES - 2) - count);
            adder_pkg::DONE:      calculation_done = 1'b1;
            default: ;
        endcase
    end

    // Only one stage moves per cycle
    a_eval_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(eval)
    ) else $error("More than one stage evaluating");

    a_clear_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(clear)
    ) else $error("More than one stage clearing");

    a_eval_clear_excl: assert property (
        @(posedge clk) disable iff (reset) !((|eval) && (|clear))
    ) else $error("Evaluate and clear overlap");

endmodule

// File: pg_stage.sv
`timescale 1ns/10ps
// Generate and propagate stage

module pg_stage #(
    parameter int WIDTH = adder_pkg::DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             eval,
    input  logic             clear,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin_in,
    output logic [WIDTH-1:0] g,
    output logic [WIDTH-1:0] p,
    output logic [WIDTH-1:0] hp,
    output logic             cin_out
);

    logic [WIDTH-1:0] half_sum;
    logic [WIDTH-1:0] gen;

    assign half_sum = a ^ b;

    // Carry-in sits below bit 0, so g[i] is the carry out of bit i from here on
    always_comb begin
        gen    = a & b;
        gen[0] = (a[0] & b[0]) | (half_sum[0] & cin_in);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            g       <= '0;
            p       <= '0;
            hp      <= '0;
            cin_out <= 1'b0;
        end else if (clear) begin
            g       <= '0;
            p       <= '0;
            hp      <= '0;
            cin_out <= 1'b0;
        end else if (eval) begin
            g       <= gen;
            p       <= half_sum;
            hp      <= half_sum;  // Kept apart, p gets merged into groups
            cin_out <= cin_in;
        end
    end

endmodule

// File: prefix_level.sv
`timescale 1ns/10ps
// One Brent-Kung prefix level
// Up-sweep below log2(WIDTH), down-sweep above

module prefix_level #(
    parameter int WIDTH = adder_pkg::DEFAULT_WIDTH,
    parameter int LEVEL = 0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             eval,
    input  logic             clear,
    input  logic [WIDTH-1:0] g_in,
    input  logic [WIDTH-1:0] p_in,
    input  logic [WIDTH-1:0] hp_in,
    input  logic             cin_in,
    output logic [WIDTH-1:0] g_out,
    output logic [WIDTH-1:0] p_out,
    output logic [WIDTH-1:0] hp_out,
    output logic             cin_out
);

    localparam int  LEVELS = $clog2(WIDTH);
    localparam bit  UP     = (LEVEL < LEVELS);
    // Distance to the partner bit, shrinking again on the way down
    localparam int  SPAN   = UP ? (1 << LEVEL) : (1 << (2 * LEVELS - 2 - LEVEL));

    logic [WIDTH-1:0] g_nxt;
    logic [WIDTH-1:0] p_nxt;

    for (genvar i = 0; i < WIDTH; i++) begin : g_bit
        if (UP && ((i + 1) % (2 * SPAN) == 0)) begin : g_black
            // Black cell merges two adjacent groups
            assign g_nxt[i] = g_in[i] | (p_in[i] & g_in[i-SPAN]);
            assign p_nxt[i] = p_in[i] & p_in[i-SPAN];
        end else if (!UP && ((i + 1) % (2 * SPAN) == SPAN) && (i >= 2 * SPAN - 1))
        begin : g_gray
            // Gray cell, partner already holds the full prefix down to bit 0
            assign g_nxt[i] = g_in[i] | (p_in[i] & g_in[i-SPAN]);
            assign p_nxt[i] = p_in[i];
        end else begin : g_pass
            assign g_nxt[i] = g_in[i];
            assign p_nxt[i] = p_in[i];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            g_out   <= '0;
            p_out   <= '0;
            hp_out  <= '0;
            cin_out <= 1'b0;
        end else if (clear) begin
            g_out   <= '0;
            p_out   <= '0;
            hp_out  <= '0;
            cin_out <= 1'b0;
        end else if (eval) begin
            g_out   <= g_nxt;
            p_out   <= p_nxt;
            hp_out  <= hp_in;
            cin_out <= cin_in;
        end
    end

    // Strobes come from the sequencer and must never collide here
    a_no_eval_clear: assert property (
        @(posedge clk) disable iff (reset) !(eval && clear)
    ) else $error("Prefix level %0d got eval and clear together", LEVEL);

endmodule

// File: sum_stage.sv
`timescale 1ns/10ps
// Sum and carry-out stage

module sum_stage #(
    parameter int WIDTH = adder_pkg::DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             eval,
    input  logic [WIDTH-1:0] g_in,
    input  logic [WIDTH-1:0] hp_in,
    input  logic             cin_in,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [WIDTH-1:0] carry;    // Carry into each bit

    assign carry = {g_in[WIDTH-2:0], cin_in};

    // Result holds until the next round evaluates this stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum  <= '0;
            cout <= 1'b0;
        end else if (eval) begin
            sum  <= hp_in ^ carry;
            cout <= g_in[WIDTH-1];  // Full prefix of the top bit
        end
    end

endmodule

// File: bk_adder_top.sv
`timescale 1ns/10ps
// Clocked Brent-Kung adder top level

module bk_adder_top #(
    parameter int WIDTH = adder_pkg::DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout,
    output logic             calculation_done
);

    localparam int LEVELS     = $clog2(WIDTH);
    localparam int NUM_PREFIX = 2 * LEVELS - 1;
    localparam int NUM_STAGES = 2 * LEVELS + 1;

    logic [NUM_STAGES-1:0] eval;
    logic [NUM_STAGES-1:0] clear;

    // Stage k output feeds stage k+1
    logic [WIDTH-1:0]      g_s  [NUM_PREFIX+1];
    logic [WIDTH-1:0]      p_s  [NUM_PREFIX+1];
    logic [WIDTH-1:0]      hp_s [NUM_PREFIX+1];
    logic [NUM_PREFIX:0]   cin_s;

    phase_sequencer #(
        .WIDTH (WIDTH)
    ) u_seq (
        .clk              (clk),
        .reset            (reset),
        .eval             (eval),
        .clear            (clear),
        .calculation_done (calculation_done)
    );

    pg_stage #(
        .WIDTH (WIDTH)
    ) u_pg (
        .clk     (clk),
        .reset   (reset),
        .eval    (eval[0]),
        .clear   (clear[0]),
        .a       (a),
        .b       (b),
        .cin_in  (cin),
        .g       (g_s[0]),
        .p       (p_s[0]),
        .hp      (hp_s[0]),
        .cin_out (cin_s[0])
    );

    for (genvar l = 0; l < NUM_PREFIX; l++) begin : g_level
        prefix_level #(
            .WIDTH (WIDTH),
            .LEVEL (l)
        ) u_level (
            .clk     (clk),
            .reset   (reset),
            .eval    (eval[l+1]),
            .clear   (clear[l+1]),
            .g_in    (g_s[l]),
            .p_in    (p_s[l]),
            .hp_in   (hp_s[l]),
            .cin_in  (cin_s[l]),
            .g_out   (g_s[l+1]),
            .p_out   (p_s[l+1]),
            .hp_out  (hp_s[l+1]),
            .cin_out (cin_s[l+1])
        );
    end

    // Last stage has no clear strobe, clear[NUM_STAGES-1] stays low
    sum_stage #(
        .WIDTH (WIDTH)
    ) u_sum (
        .clk    (clk),
        .reset  (reset),
        .eval   (eval[NUM_STAGES-1]),
        .g_in   (g_s[NUM_PREFIX]),
        .hp_in  (hp_s[NUM_PREFIX]),
        .cin_in (cin_s[NUM_PREFIX]),
        .sum    (sum),
        .cout   (cout)
    );

endmodule

// File: adder_checker.sv
`timescale 1ns/10ps
// Adder result and round timing checker

module adder_checker #(
    parameter int WIDTH = adder_pkg::DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] sum,
    input  logic             cout,
    input  logic             calculation_done,
    input  logic [WIDTH-1:0] exp_sum,
    input  logic             exp_cout,
    input  int               test_idx,
    output int               error_count,
    output int               check_count
);

    localparam int LEVELS       = $clog2(WIDTH);
    localparam int NUM_STAGES   = 2 * LEVELS + 1;
    localparam int PERIOD       = 2 * NUM_STAGES + 1;
    // New result shows one sample after the last ramp-up edge
    localparam int RESULT_CYCLE = NUM_STAGES + 2;

    int               errors    = 0;
    int               checks    = 0;
    int               cycle_cnt = 0;    // Edges since reset release or last done
    logic [WIDTH-1:0] prev_sum  = '0;
    logic             prev_cout = 1'b0;
    logic             prev_done = 1'b0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic check_result();
        checks++;
        if (sum !== exp_sum || cout !== exp_cout) begin
            $display("[FAIL] %0t: test %0d got cout %b sum %h, expected cout %b sum %h",
                     $time, test_idx, cout, sum, exp_cout, exp_sum);
            errors++;
        end else begin
            $display("[ OK ] %0t: test %0d cout %b sum %h", $time, test_idx, cout, sum);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (sum !== '0 || cout !== 1'b0 || calculation_done !== 1'b0) begin
                $display("[FAIL] %0t: outputs not zero in reset, sum %h cout %b done %b",
                         $time, sum, cout, calculation_done);
                errors++;
            end
            cycle_cnt = 0;
        end else begin
            cycle_cnt++;
            if ((sum !== prev_sum || cout !== prev_cout) && cycle_cnt != RESULT_CYCLE) begin
                $display("[FAIL] %0t: result changed in cycle %0d of the round, not in %0d",
                         $time, cycle_cnt, RESULT_CYCLE);
                errors++;
            end
            if (calculation_done && prev_done) begin
                $display("Done pulse at %0t is wider than one cycle", $time);
                errors++;
            end
            if (calculation_done) begin
                if (cycle_cnt != PERIOD) begin
                    $display("Period violation at %0t: done came %0d cycles into the round, not %0d",
                             $time, cycle_cnt, PERIOD);
                    errors++;
                end
                check_result();
                cycle_cnt = 0;
            end else if (cycle_cnt == PERIOD) begin
                $display("Period violation at %0t: no done pulse %0d cycles into the round",
                         $time, PERIOD);
                errors++;
            end
        end
        prev_sum  = sum;
        prev_cout = cout;
        prev_done = calculation_done;
    end

endmodule

// File: tb_bk_adder.sv
`timescale 1ns/10ps
// Brent-Kung adder testbench

module tb_bk_adder;

    localparam int WIDTH        = adder_pkg::DEFAULT_WIDTH;
    localparam int NUM_DIRECTED = 10;
    localparam int NUM_RANDOM   = 40;
    localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM;
    localparam int SEED         = 74;
    localparam int DONE_TIMEOUT = 60;   // Cycles, about three rounds
    localparam int DECOY_DELAY  = 6;    // Cycles after done, well past the sampling edge
    localparam int RESET_DELAY  = 7;    // Reset lands in the middle of the ramp-up

    logic             clk;
    logic             reset;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic             cin;
    logic [WIDTH-1:0] sum;
    logic             cout;
    logic             calculation_done;

    logic [WIDTH-1:0] exp_sum;
    logic             exp_cout;
    int               test_idx;
    int               error_count;
    int               check_count;

    // Stimulus table, one entry per test
    logic [WIDTH-1:0] row_a     [NUM_ROWS];
    logic [WIDTH-1:0] row_b     [NUM_ROWS];
    logic             row_cin   [NUM_ROWS];
    logic [WIDTH-1:0] row_sum   [NUM_ROWS];
    logic             row_cout  [NUM_ROWS];
    bit               row_decoy [NUM_ROWS];
    bit               row_reset [NUM_ROWS];

    bk_adder_top #(
        .WIDTH (WIDTH)
    ) u_dut (
        .clk              (clk),
        .reset            (reset),
        .a                (a),
        .b                (b),
        .cin              (cin),
        .sum              (sum),
        .cout             (cout),
        .calculation_done (calculation_done)
    );

    adder_checker #(
        .WIDTH (WIDTH)
    ) u_chk (
        .clk              (clk),
        .reset            (reset),
        .sum              (sum),
        .cout             (cout),
        .calculation_done (calculation_done),
        .exp_sum          (exp_sum),
        .exp_cout         (exp_cout),
        .test_idx         (test_idx),
        .error_count      (error_count),
        .check_count      (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_row(input int idx, input logic [WIDTH-1:0] op_a,
                           input logic [WIDTH-1:0] op_b, input logic op_cin,
                           input logic [WIDTH-1:0] res, input logic carry,
                           input bit decoy, input bit mid_reset);
        row_a[idx]     = op_a;
        row_b[idx]     = op_b;
        row_cin[idx]   = op_cin;
        row_sum[idx]   = res;
        row_cout[idx]  = carry;
        row_decoy[idx] = decoy;
        row_reset[idx] = mid_reset;
    endtask

    task automatic fill_table();
        logic [WIDTH:0] total;
        add_row(0, 16'h0000, 16'h0000, 1'b0, 16'h0000, 1'b0, 0, 0);
        add_row(1, 16'hFFFF, 16'h0000, 1'b1, 16'h0000, 1'b1, 0, 0);  // Carry ripples all the way
        add_row(2, 16'hAAAA, 16'h5555, 1'b0, 16'hFFFF, 1'b0, 0, 0);
        add_row(3, 16'hAAAA, 16'h5555, 1'b1, 16'h0000, 1'b1, 1, 0);
        add_row(4, 16'h5555, 16'h5555, 1'b0, 16'hAAAA, 1'b0, 0, 0);
        add_row(5, 16'h0000, 16'h0000, 1'b1, 16'h0001, 1'b0, 0, 0);
        add_row(6, 16'hFFFF, 16'hFFFF, 1'b1, 16'hFFFF, 1'b1, 1, 0);
        add_row(7, 16'h8000, 16'h8000, 1'b0, 16'h0000, 1'b1, 0, 0);
        add_row(8, 16'h1234, 16'h4321, 1'b0, 16'h5555, 1'b0, 0, 1);
        add_row(9, 16'h7FFF, 16'h0001, 1'b0, 16'h8000, 1'b0, 0, 0);
        for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
            row_a[i]   = WIDTH'($urandom);
            row_b[i]   = WIDTH'($urandom);
            row_cin[i] = 1'($urandom % 2);
            total = (WIDTH+1)'(row_a[i]) + (WIDTH+1)'(row_b[i]) + (WIDTH+1)'(row_cin[i]);
            row_sum[i]   = total[WIDTH-1:0];
            row_cout[i]  = total[WIDTH];
            row_decoy[i] = (i % 8 == 3);
            row_reset[i] = (i == NUM_ROWS - 5);
        end
    endtask

    task automatic apply_row(input int idx);
        a        = row_a[idx];
        b        = row_b[idx];
        cin      = row_cin[idx];
        exp_sum  = row_sum[idx];
        exp_cout = row_cout[idx];
        test_idx = idx;
    endtask

    // Returns on the edge where done is seen, or gives up
    task automatic wait_done(output bit late);
        int  cycles;
        bit  seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            seen = calculation_done;
            cycles++;
        end
        late = !seen;
    endtask

    initial begin
        bit late;
        bit timed_out;
        reset     = 1'b1;
        a         = '0;
        b         = '0;
        cin       = 1'b0;
        exp_sum   = '0;
        exp_cout  = 1'b0;
        test_idx  = 0;
        timed_out = 1'b0;
        void'($urandom(SEED));
        fill_table();

        repeat (2) @(posedge clk);
        #1;
        apply_row(0);
        reset = 1'b0;

        for (int n = 0; n < NUM_ROWS && !timed_out; n++) begin
            if (n > 0)
                apply_row(n);
            if (row_decoy[n]) begin
                repeat (DECOY_DELAY) @(posedge clk);
                #1;
                a   = ~row_a[n];
                b   = ~row_b[n];
                cin = ~row_cin[n];
            end
            if (row_reset[n]) begin
                repeat (RESET_DELAY) @(posedge clk);
                #1 reset = 1'b1;
                repeat (2) @(posedge clk);
                #1 reset = 1'b0;
            end
            wait_done(late);
            if (late) begin
                $display("Timeout: no calculation_done within %0d cycles on test %0d",
                         DONE_TIMEOUT, n);
                timed_out = 1'b1;
            end else begin
                #1;
            end
        end

        @(posedge clk);
        #1;
        $display("Tests checked: %0d of %0d, errors: %0d", check_count, NUM_ROWS, error_count);
        if (timed_out || error_count != 0 || check_count != NUM_ROWS) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

// File: filelist.f
adder_pkg.sv
phase_sequencer.sv
pg_stage.sv
prefix_level.sv
sum_stage.sv
bk_adder_top.sv
adder_checker.sv
tb_bk_adder.sv

// File: Makefile
# Verilator build and run for the Brent-Kung adder

VERILATOR ?= verilator
TOP       ?= tb_bk_adder
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Verification passed

SRCS := $(wildcard *.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass message appears as a line of its own
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
